/* design/sram_pkg.sv */
package sram_pkg;

	//////////////////////////////////////////////////
	// Bus and lane geometry
	//////////////////////////////////////////////////

	localparam int ADDR_W = 12;
	localparam int WORD_W = 48;
	localparam int CPU_W  = 32;     // Low lane
	localparam int PIX_W  = 16;     // High lane

	localparam int CPU_LSB = 0;
	localparam int PIX_LSB = 32;

	typedef logic [ADDR_W-1:0] sram_addr_t;
	typedef logic [WORD_W-1:0] sram_word_t;
	typedef logic [CPU_W-1:0]  cpu_word_t;
	typedef logic [PIX_W-1:0]  pixel_t;

	//////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////

	// Boot image region, copied once after reset
	localparam sram_addr_t BOOT_BASE = 12'h800;
	localparam int BOOT_LEN   = 16;
	localparam int BOOT_IDX_W = $clog2(BOOT_LEN);

	// Frame region walked by the scanout
	localparam sram_addr_t SCAN_BASE = 12'h000;
	localparam int SCAN_LEN   = 64;
	localparam int SCAN_IDX_W = $clog2(SCAN_LEN);

	//////////////////////////////////////////////////
	// Timing
	//////////////////////////////////////////////////

	// Cycles from reset release to the first boot write
	localparam int BOOT_DELAY = 10;
	localparam int DELAY_W    = $clog2(BOOT_DELAY + 1);

	localparam BOOT_FILE = "boot_image.hex";   // One 48-bit hex word per line

endpackage

/* design/client_port.sv */
`timescale 1ns/1ns

module client_port import sram_pkg::*; #(
	parameter type payload_t = cpu_word_t,
	parameter int  LANE_LSB  = CPU_LSB
) (
	input  logic       clk_50mhz,
	input  logic       arst_n,

	// Client side, four-phase req/ack
	input  logic       req,
	input  logic       we,
	input  sram_addr_t addr,
	input  payload_t   wdata,
	output payload_t   rdata,
	output logic       ack,

	// Control side
	output logic       acc_req,
	output logic       acc_we,
	output sram_addr_t acc_addr,
	output sram_word_t merge_word,
	input  logic       grant,
	input  logic       rd_cap,
	input  logic       done,
	input  sram_word_t sram_rdata
);

	logic       busy;       // Granted, waiting for done
	logic       start;
	payload_t   wdata_q;
	sram_word_t cap_word;   // Last word read for this client

	// New request only once the previous ack has fallen
	assign start = req && !ack && !acc_req && !busy;

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			acc_req <= 1'b0;
			busy    <= 1'b0;
			ack     <= 1'b0;
		end else begin
			if (start)
				acc_req <= 1'b1;
			if (grant) begin
				acc_req <= 1'b0;
				busy    <= 1'b1;
			end
			if (done) begin
				busy <= 1'b0;
				ack  <= 1'b1;
			end else if (ack && !req) begin
				ack <= 1'b0;   // Falls one cycle after req
			end
		end
	end

	// Request payload and read capture
	always_ff @(posedge clk_50mhz) begin
		if (start) begin
			acc_we   <= we;
			acc_addr <= addr;
			wdata_q  <= wdata;
		end
		if (rd_cap)
			cap_word <= sram_rdata;
	end

	assign rdata = payload_t'(cap_word[LANE_LSB +: $bits(payload_t)]);

	// Read-modify-write word, other lane kept as read
	always_comb begin
		merge_word = cap_word;
		merge_word[LANE_LSB +: $bits(payload_t)] = wdata_q;
	end

	a_ack_hold: assert property (@(posedge clk_50mhz) disable iff (!arst_n)
		ack && req |=> ack)
		else $error("client_port ack dropped while req still high");

endmodule

/* design/sram_ctrl.sv */
`timescale 1ns/1ns

module sram_ctrl import sram_pkg::*; (
	input  logic       clk_50mhz,
	input  logic       arst_n,

	input  logic       cpu_acc_req,
	input  logic       cpu_acc_we,
	input  sram_addr_t cpu_acc_addr,
	input  sram_word_t cpu_merge,
	input  logic       vid_acc_req,
	input  logic       vid_acc_we,
	input  sram_addr_t vid_acc_addr,
	input  sram_word_t vid_merge,

	output logic       cpu_grant,
	output logic       cpu_rd_cap,
	output logic       cpu_done,
	output logic       vid_grant,
	output logic       vid_rd_cap,
	output logic       vid_done,

	input  logic       boot_active,
	input  sram_addr_t boot_addr,
	input  sram_word_t boot_data,
	output logic       boot_step,
	output logic       boot_done,

	input  sram_addr_t scan_addr,
	output logic       scan_slot,
	output sram_word_t sram_rdata,

	// SRAM pins
	output sram_addr_t sram_addr,
	output logic       sram_oe_n,
	output logic       sram_we_n,
	output sram_word_t sram_dq_out,
	output logic       sram_dq_oe,
	input  sram_word_t sram_dq_in
);

	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE, ST_FINISH} ctrl_state_t;

	ctrl_state_t state;
	logic        owner_vid;       // Client of the access in progress
	logic        boot_active_q;
	logic        access_slot;
	logic        idle_slot;
	logic        clients_open;
	logic        any_grant;
	logic        rd_slot;
	logic        wr_slot;
	logic        wr_en;
	logic        rd_en;
	logic        owner_we;
	sram_addr_t  owner_addr;
	sram_word_t  owner_merge;

	//////////////////////////////////////////////////
	// Slot phase and arbitration
	//////////////////////////////////////////////////

	assign access_slot  = !scan_slot;
	assign idle_slot    = access_slot && state == ST_IDLE;
	assign clients_open = boot_done && !boot_active;   // Held off until the copy ends

	assign boot_step = idle_slot && boot_active;
	assign cpu_grant = idle_slot && clients_open && cpu_acc_req;
	assign vid_grant = idle_slot && clients_open && vid_acc_req && !cpu_acc_req;
	assign any_grant = cpu_grant || vid_grant;

	assign owner_we    = owner_vid ? vid_acc_we   : cpu_acc_we;
	assign owner_addr  = owner_vid ? vid_acc_addr : cpu_acc_addr;
	assign owner_merge = owner_vid ? vid_merge    : cpu_merge;

	assign rd_slot = access_slot && state == ST_READ;
	assign wr_slot = access_slot && state == ST_WRITE;

	assign cpu_rd_cap = rd_slot && !owner_vid;
	assign vid_rd_cap = rd_slot && owner_vid;
	assign cpu_done = !owner_vid && ((rd_slot && !owner_we) || wr_slot);
	assign vid_done = owner_vid && ((rd_slot && !owner_we) || wr_slot);

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			scan_slot     <= 1'b0;
			state         <= ST_IDLE;
			owner_vid     <= 1'b0;
			boot_active_q <= 1'b0;
			boot_done     <= 1'b0;
		end else begin
			scan_slot     <= !scan_slot;
			boot_active_q <= boot_active;
			if (boot_active_q && !boot_active)
				boot_done <= 1'b1;   // Sticky until reset

			case (state)
				ST_IDLE: if (any_grant) begin
					owner_vid <= vid_grant;
					state     <= ST_READ;
				end
				ST_READ: if (access_slot)
					state <= owner_we ? ST_WRITE : ST_FINISH;
				ST_WRITE: if (access_slot)
					state <= ST_FINISH;
				default: state <= ST_IDLE;   // Finish falls in a scan slot
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Pin drive
	//////////////////////////////////////////////////

	assign wr_en = boot_step || wr_slot;
	assign rd_en = scan_slot || rd_slot;

	always_comb begin
		if (scan_slot)
			sram_addr = scan_addr;
		else if (boot_step)
			sram_addr = boot_addr;
		else
			sram_addr = owner_addr;
	end

	assign sram_dq_out = boot_step ? boot_data : owner_merge;
	assign sram_dq_oe  = wr_en;
	assign sram_we_n   = !wr_en;
	assign sram_oe_n   = !rd_en;
	assign sram_rdata  = sram_dq_in;

	a_we_slot: assert property (@(posedge clk_50mhz) disable iff (!arst_n)
		!sram_we_n |-> !scan_slot ##1 (sram_we_n && scan_slot))
		else $error("sram_ctrl write strobe outside a single access slot");

	// Grants at least one full access apart
	a_one_grant: assert property (@(posedge clk_50mhz) disable iff (!arst_n)
		any_grant |-> $onehot0({cpu_grant, vid_grant})
			##1 !any_grant ##1 !any_grant ##1 !any_grant)
		else $error("sram_ctrl overlapping client grants");

endmodule

/* design/boot_loader.sv */
`timescale 1ns/1ns

module boot_loader import sram_pkg::*; (
	input  logic       clk_50mhz,
	input  logic       arst_n,
	input  logic       boot_step,
	output logic       boot_active,
	output sram_addr_t boot_addr,
	output sram_word_t boot_data
);

	sram_word_t            rom [BOOT_LEN];   // Boot image
	logic [DELAY_W-1:0]    timer;
	logic [BOOT_IDX_W-1:0] word_idx;
	logic                  copy_done;

	initial begin
		$readmemh(BOOT_FILE, rom);
	end

	//////////////////////////////////////////////////
	// Delay then one word per boot_step
	//////////////////////////////////////////////////

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			timer       <= '0;
			word_idx    <= '0;
			boot_active <= 1'b0;
			copy_done   <= 1'b0;
		end else if (!boot_active && !copy_done) begin
			timer <= timer + 1'b1;
			if (timer == DELAY_W'(BOOT_DELAY - 1))
				boot_active <= 1'b1;
		end else if (boot_active && boot_step) begin
			word_idx <= word_idx + 1'b1;
			// Last word written this slot
			if (word_idx == BOOT_IDX_W'(BOOT_LEN - 1)) begin
				boot_active <= 1'b0;
				copy_done   <= 1'b1;
			end
		end
	end

	assign boot_addr = BOOT_BASE + sram_addr_t'(word_idx);
	assign boot_data = rom[word_idx];   // Async ROM read

endmodule

/* design/scan_fetch.sv */
`timescale 1ns/1ns

module scan_fetch import sram_pkg::*; (
	input  logic       clk_50mhz,
	input  logic       arst_n,
	input  logic       scan_slot,
	input  sram_word_t sram_rdata,
	output sram_addr_t scan_addr,
	output sram_addr_t scan_index,
	output pixel_t     scan_pixel
);

	logic [SCAN_IDX_W-1:0] scan_off;   // Offset into the frame region
	logic                  last_word;

	assign scan_addr = SCAN_BASE + sram_addr_t'(scan_off);
	assign last_word = scan_off == SCAN_IDX_W'(SCAN_LEN - 1);

	//////////////////////////////////////////////////
	// Raster walk of one word per scan slot
	//////////////////////////////////////////////////

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			scan_off   <= '0;
			scan_index <= SCAN_BASE;
			scan_pixel <= '0;
		end else if (scan_slot) begin
			// Pixel tagged with the address it came from
			scan_pixel <= sram_rdata[PIX_LSB +: PIX_W];
			scan_index <= scan_addr;
			if (last_word)
				scan_off <= '0;   // Wrap to the frame start
			else
				scan_off <= scan_off + 1'b1;
		end
	end

endmodule

/* design/sram_subsystem.sv */
`timescale 1ns/1ns

module sram_subsystem import sram_pkg::*; (
	input  logic       clk_50mhz,
	input  logic       arst_n,

	// CPU client, low lane
	input  logic       cpu_req,
	input  logic       cpu_we,
	input  sram_addr_t cpu_addr,
	input  cpu_word_t  cpu_wdata,
	output cpu_word_t  cpu_rdata,
	output logic       cpu_ack,

	// Video client, high lane
	input  logic       vid_req,
	input  logic       vid_we,
	input  sram_addr_t vid_addr,
	input  pixel_t     vid_wdata,
	output pixel_t     vid_rdata,
	output logic       vid_ack,

	output sram_addr_t scan_index,
	output pixel_t     scan_pixel,
	output logic       boot_done,

	output sram_addr_t sram_addr,
	output logic       sram_oe_n,
	output logic       sram_we_n,
	output sram_word_t sram_dq_out,
	output logic       sram_dq_oe,
	input  sram_word_t sram_dq_in
);

	logic       cpu_acc_req, cpu_acc_we, cpu_grant, cpu_rd_cap, cpu_done;
	logic       vid_acc_req, vid_acc_we, vid_grant, vid_rd_cap, vid_done;
	sram_addr_t cpu_acc_addr, vid_acc_addr;
	sram_word_t cpu_merge, vid_merge;
	logic       boot_active, boot_step, scan_slot;
	sram_addr_t boot_addr, scan_addr;
	sram_word_t boot_data, sram_rdata;

	//////////////////////////////////////////////////
	// Client front ends
	//////////////////////////////////////////////////

	client_port #(.payload_t(cpu_word_t), .LANE_LSB(CPU_LSB)) u_cpu_port (
		.clk_50mhz(clk_50mhz), .arst_n(arst_n),
		.req(cpu_req), .we(cpu_we), .addr(cpu_addr), .wdata(cpu_wdata),
		.rdata(cpu_rdata), .ack(cpu_ack),
		.acc_req(cpu_acc_req), .acc_we(cpu_acc_we), .acc_addr(cpu_acc_addr),
		.merge_word(cpu_merge), .grant(cpu_grant), .rd_cap(cpu_rd_cap),
		.done(cpu_done), .sram_rdata(sram_rdata)
	);

	client_port #(.payload_t(pixel_t), .LANE_LSB(PIX_LSB)) u_vid_port (
		.clk_50mhz(clk_50mhz), .arst_n(arst_n),
		.req(vid_req), .we(vid_we), .addr(vid_addr), .wdata(vid_wdata),
		.rdata(vid_rdata), .ack(vid_ack),
		.acc_req(vid_acc_req), .acc_we(vid_acc_we), .acc_addr(vid_acc_addr),
		.merge_word(vid_merge), .grant(vid_grant), .rd_cap(vid_rd_cap),
		.done(vid_done), .sram_rdata(sram_rdata)
	);

	sram_ctrl u_sram_ctrl (
		.clk_50mhz(clk_50mhz), .arst_n(arst_n),
		.cpu_acc_req(cpu_acc_req), .cpu_acc_we(cpu_acc_we),
		.cpu_acc_addr(cpu_acc_addr), .cpu_merge(cpu_merge),
		.vid_acc_req(vid_acc_req), .vid_acc_we(vid_acc_we),
		.vid_acc_addr(vid_acc_addr), .vid_merge(vid_merge),
		.cpu_grant(cpu_grant), .cpu_rd_cap(cpu_rd_cap), .cpu_done(cpu_done),
		.vid_grant(vid_grant), .vid_rd_cap(vid_rd_cap), .vid_done(vid_done),
		.boot_active(boot_active), .boot_addr(boot_addr), .boot_data(boot_data),
		.boot_step(boot_step), .boot_done(boot_done),
		.scan_addr(scan_addr), .scan_slot(scan_slot), .sram_rdata(sram_rdata),
		.sram_addr(sram_addr), .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n),
		.sram_dq_out(sram_dq_out), .sram_dq_oe(sram_dq_oe), .sram_dq_in(sram_dq_in)
	);

	boot_loader u_boot_loader (
		.clk_50mhz(clk_50mhz), .arst_n(arst_n), .boot_step(boot_step),
		.boot_active(boot_active), .boot_addr(boot_addr), .boot_data(boot_data)
	);

	scan_fetch u_scan_fetch (
		.clk_50mhz(clk_50mhz), .arst_n(arst_n), .scan_slot(scan_slot),
		.sram_rdata(sram_rdata), .scan_addr(scan_addr),
		.scan_index(scan_index), .scan_pixel(scan_pixel)
	);

endmodule

/* verif/sram_model.sv */
`timescale 1ns/1ns

module sram_model import sram_pkg::*; (
	input  logic       clk_50mhz,
	input  sram_addr_t sram_addr,
	input  logic       sram_oe_n,
	input  logic       sram_we_n,
	input  sram_word_t sram_dq_out,
	input  logic       sram_dq_oe,
	output sram_word_t sram_dq_in
);

	sram_word_t mem [1 << ADDR_W];
	sram_word_t dq_bus;   // Resolved data bus

	// Power-up contents, every address bit shows up in the word
	function automatic sram_word_t fill_word(input sram_addr_t a);
		return {a, ~a, a ^ 12'h5a5, a + 12'h3c3};
	endfunction

	initial begin
		for (int a = 0; a < (1 << ADDR_W); a++)
			mem[a] = fill_word(sram_addr_t'(a));
	end

	//////////////////////////////////////////////////
	// Bus resolution
	//////////////////////////////////////////////////

	always_comb begin
		if (sram_dq_oe)
			dq_bus = sram_dq_out;   // Controller drives the bus
		else if (!sram_oe_n)
			dq_bus = mem[sram_addr];
		else
			dq_bus = '0;            // Floating bus reads as zero
	end

	assign sram_dq_in = dq_bus;

	// Write taken at the end of the strobe
	always @(posedge clk_50mhz) begin
		if (!sram_we_n && sram_dq_oe)
			mem[sram_addr] <= sram_dq_out;
	end

endmodule

/* verif/tb_sram_subsystem.sv */
`timescale 1ns/1ns

module tb_sram_subsystem import sram_pkg::*; ();

	localparam logic [1:0] OP_CPU  = 2'd0;
	localparam logic [1:0] OP_VID  = 2'd1;
	localparam logic [1:0] OP_BOTH = 2'd2;
	localparam int NUM_OPS = 20;
	localparam int WATCH_CYCLES = (NUM_OPS + BOOT_LEN) * 40 + BOOT_DELAY + 2 * BOOT_LEN
		+ 10 + 4 * SCAN_LEN + 100;

	typedef struct packed {
		logic [1:0] op;
		logic       we;
		sram_addr_t addr;
		logic [3:0] hold;   // Extra cycles req stays high after ack
	} op_row_t;

	logic       clk_50mhz, arst_n;
	logic       cpu_req, cpu_we, vid_req, vid_we;
	sram_addr_t cpu_addr, vid_addr, scan_index, sram_addr;
	cpu_word_t  cpu_wdata, cpu_rdata;
	pixel_t     vid_wdata, vid_rdata, scan_pixel;
	logic       cpu_ack, vid_ack, boot_done;
	logic       sram_oe_n, sram_we_n, sram_dq_oe;
	sram_word_t sram_dq_out, sram_dq_in;

	sram_word_t  ref_mem [1 << ADDR_W];
	sram_word_t  boot_img [BOOT_LEN];
	logic [31:0] lfsr = 32'h474d;

	op_row_t op_table [NUM_OPS] = '{
		'{OP_CPU,  1'b1, 12'h005, 4'd0}, '{OP_CPU,  1'b0, 12'h005, 4'd0},
		'{OP_VID,  1'b0, 12'h005, 4'd0}, '{OP_VID,  1'b1, 12'h005, 4'd0},
		'{OP_CPU,  1'b0, 12'h005, 4'd0}, '{OP_VID,  1'b0, 12'h005, 4'd0},
		'{OP_VID,  1'b1, 12'h010, 4'd0}, '{OP_CPU,  1'b1, 12'h010, 4'd0},
		'{OP_BOTH, 1'b1, 12'h020, 4'd0}, '{OP_BOTH, 1'b0, 12'h020, 4'd0},
		'{OP_CPU,  1'b0, 12'h123, 4'd5}, '{OP_VID,  1'b1, 12'h03f, 4'd3},
		'{OP_VID,  1'b0, 12'h03f, 4'd0}, '{OP_BOTH, 1'b1, 12'h800, 4'd0},
		'{OP_CPU,  1'b0, 12'h800, 4'd0}, '{OP_CPU,  1'b1, 12'hfff, 4'd0},
		'{OP_VID,  1'b0, 12'hfff, 4'd0}, '{OP_VID,  1'b1, 12'h000, 4'd0},
		'{OP_BOTH, 1'b0, 12'h000, 4'd0}, '{OP_CPU,  1'b0, 12'h7ff, 4'd2}
	};

	sram_subsystem u_sram_subsystem (.*);

	sram_model u_sram_model (
		.clk_50mhz(clk_50mhz), .sram_addr(sram_addr), .sram_oe_n(sram_oe_n),
		.sram_we_n(sram_we_n), .sram_dq_out(sram_dq_out), .sram_dq_oe(sram_dq_oe),
		.sram_dq_in(sram_dq_in)
	);

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic report_fail(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Same power-up pattern as the SRAM model
	function automatic sram_word_t fill_word(input sram_addr_t a);
		return {a, ~a, a ^ 12'h5a5, a + 12'h3c3};
	endfunction

	// Check a read or record a write once ack is seen
	task automatic finish_access(input logic is_vid, input logic wr, input sram_addr_t a,
		input logic [31:0] d);
		if (is_vid && wr)
			ref_mem[a][PIX_LSB +: PIX_W] = pixel_t'(d);
		else if (wr)
			ref_mem[a][CPU_LSB +: CPU_W] = d;
		else if (is_vid)
			assert (vid_rdata == ref_mem[a][PIX_LSB +: PIX_W]) else
				report_fail($sformatf("video read %h got %h expected %h", a, vid_rdata,
					ref_mem[a][PIX_LSB +: PIX_W]));
		else
			assert (cpu_rdata == ref_mem[a][CPU_LSB +: CPU_W]) else
				report_fail($sformatf("cpu read %h got %h expected %h", a, cpu_rdata,
					ref_mem[a][CPU_LSB +: CPU_W]));
	endtask

	task automatic run_single(input logic is_vid, input logic wr, input sram_addr_t a,
		input int hold);
		logic [31:0] d;
		draw_bits(is_vid ? PIX_W : CPU_W, d);
		@(posedge clk_50mhz);
		if (is_vid) begin
			vid_req   <= 1'b1;
			vid_we    <= wr;
			vid_addr  <= a;
			vid_wdata <= pixel_t'(d);
		end else begin
			cpu_req   <= 1'b1;
			cpu_we    <= wr;
			cpu_addr  <= a;
			cpu_wdata <= d;
		end
		do @(posedge clk_50mhz); while (!(is_vid ? vid_ack : cpu_ack));
		finish_access(is_vid, wr, a, d);
		for (int i = 0; i < hold; i++) begin
			@(posedge clk_50mhz);
			assert (is_vid ? vid_ack : cpu_ack) else
				report_fail("ack dropped while req was still held high");
		end
		if (is_vid)
			vid_req <= 1'b0;
		else
			cpu_req <= 1'b0;
		@(posedge clk_50mhz);
		assert (is_vid ? vid_ack : cpu_ack) else
			report_fail("ack fell in the same cycle as req");
		@(posedge clk_50mhz);
		assert (!(is_vid ? vid_ack : cpu_ack)) else
			report_fail("ack still high one cycle after req fell");
	endtask

	// Both clients at once with the CPU winning
	task automatic run_both(input logic wr, input sram_addr_t a);
		logic [31:0] dc;
		logic [31:0] dv;
		int          cyc;
		int          cpu_at;
		int          vid_at;
		draw_bits(CPU_W, dc);
		draw_bits(PIX_W, dv);
		cyc    = 0;
		cpu_at = -1;
		vid_at = -1;
		@(posedge clk_50mhz);
		cpu_req   <= 1'b1;
		cpu_we    <= wr;
		cpu_addr  <= a;
		cpu_wdata <= dc;
		vid_req   <= 1'b1;
		vid_we    <= wr;
		vid_addr  <= a;
		vid_wdata <= pixel_t'(dv);
		while (cpu_at < 0 || vid_at < 0) begin
			@(posedge clk_50mhz);
			cyc++;
			if (cpu_ack && cpu_at < 0) begin
				cpu_at = cyc;
				finish_access(1'b0, wr, a, dc);
				cpu_req <= 1'b0;
			end
			if (vid_ack && vid_at < 0) begin
				vid_at = cyc;
				finish_access(1'b1, wr, a, dv);
				vid_req <= 1'b0;
			end
		end
		assert (cpu_at < vid_at) else
			report_fail($sformatf("video ack at %0d not after cpu ack at %0d", vid_at, cpu_at));
		do @(posedge clk_50mhz); while (cpu_ack || vid_ack);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		arst_n    = 1'b0;
		cpu_req   = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		vid_req   = 1'b0;
		vid_we    = 1'b0;
		vid_addr  = '0;
		vid_wdata = '0;
		$readmemh(BOOT_FILE, boot_img);
		for (int a = 0; a < (1 << ADDR_W); a++)
			ref_mem[a] = fill_word(sram_addr_t'(a));
		for (int i = 0; i < BOOT_LEN; i++)
			ref_mem[BOOT_BASE + sram_addr_t'(i)] = boot_img[i];

		repeat (10) @(posedge clk_50mhz);
		arst_n <= 1'b1;
		@(posedge clk_50mhz);
		assert (!cpu_ack && !vid_ack && !boot_done) else
			report_fail("ack or boot_done active right after reset");
		assert (sram_we_n && sram_oe_n && !sram_dq_oe) else
			report_fail("SRAM strobe or data drive active right after reset");
		while (!boot_done) @(posedge clk_50mhz);

		for (int i = 0; i < BOOT_LEN; i++)   // Boot image in both lanes
			run_both(1'b0, BOOT_BASE + sram_addr_t'(i));

		for (int i = 0; i < NUM_OPS; i++) begin
			if (op_table[i].op == OP_BOTH)
				run_both(op_table[i].we, op_table[i].addr);
			else
				run_single(op_table[i].op == OP_VID, op_table[i].we,
					op_table[i].addr, int'(op_table[i].hold));
		end

		// Two full passes of the frame on a quiet bus
		repeat (4 * SCAN_LEN) begin
			@(posedge clk_50mhz);
			assert (scan_pixel == ref_mem[scan_index][PIX_LSB +: PIX_W]) else
				report_fail($sformatf("scan pixel %h at %h expected %h", scan_pixel,
					scan_index, ref_mem[scan_index][PIX_LSB +: PIX_W]));
		end

		$display("all tests passed");
		$finish;
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge clk_50mhz);
		$display("Watchdog timeout, the run did not finish in time");
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* sram_subsystem.f */
design/sram_pkg.sv
design/client_port.sv
design/sram_ctrl.sv
design/boot_loader.sv
design/scan_fetch.sv
design/sram_subsystem.sv
verif/sram_model.sv
verif/tb_sram_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SRAM subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sram_subsystem \
	-f sram_subsystem.f -o tb_sram_subsystem > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_sram_subsystem > sim.log 2>&1

grep -q "tests failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "all tests passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"

/* boot_image.hex */
// One 48-bit boot word per line, from BOOT_BASE upward
0123456789ab
fedcba987654
a5a55a5a0f0f
13579bdf2468
deadbeef0001
c0ffee123456
00000000ffff
ffff00000000
8000000c0001
7ffffffe1234
2468ace13579
5555aaaa3333
0f1e2d3c4b5a
6978a5b4c3d2
e1f000112233
445566778899
